// ==== common/mips_pkg.sv ====
package mips_pkg;

  typedef logic [31:0] word_t;     // Data word, address or instruction
  typedef logic [4:0]  reg_addr_t;

  // --------------------
  // Opcodes
  localparam logic [5:0] op_rtype = 6'b000000;
  localparam logic [5:0] op_lw    = 6'b100011;
  localparam logic [5:0] op_sw    = 6'b101011;
  localparam logic [5:0] op_beq   = 6'b000100;
  localparam logic [5:0] op_bne   = 6'b000101;
  localparam logic [5:0] op_addi  = 6'b001000;
  localparam logic [5:0] op_addiu = 6'b001001;

  // R-type funct codes
  localparam logic [5:0] fn_add  = 6'b100000;
  localparam logic [5:0] fn_addu = 6'b100001;
  localparam logic [5:0] fn_sub  = 6'b100010;
  localparam logic [5:0] fn_subu = 6'b100011;
  localparam logic [5:0] fn_and  = 6'b100100;
  localparam logic [5:0] fn_or   = 6'b100101;
  localparam logic [5:0] fn_slt  = 6'b101010;

  // --------------------
  localparam word_t word_bytes = 32'd4;
  localparam int    reg_count  = 32;
  localparam word_t reset_pc   = 32'h0000_0000;

  typedef enum logic [2:0] {
    alu_and = 3'b000,
    alu_or  = 3'b001,
    alu_add = 3'b010,
    alu_sub = 3'b110,
    alu_slt = 3'b111
  } alu_op_t;

  typedef enum logic [1:0] {
    fwd_none = 2'b00,
    fwd_mem  = 2'b01,   // From EX/MEM
    fwd_wb   = 2'b10    // From MEM/WB
  } fwd_sel_t;

endpackage

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit
  import mips_pkg::*;
(
  input  reg_addr_t id_rs,
  input  reg_addr_t id_rt,
  input  reg_addr_t ex_rt,
  input  logic      ex_memtoreg,
  input  logic      ex_pcsrc,
  output logic      stall,
  output logic      flush
);

  // Load in execute feeding the instruction in decode
  assign stall = ex_memtoreg && (ex_rt == id_rs || ex_rt == id_rt);

  // Taken branch kills the two younger instructions
  assign flush = ex_pcsrc;

endmodule

// ==== hdl/forward_unit.sv ====
`timescale 1ns/1ps

module forward_unit
  import mips_pkg::*;
(
  input  reg_addr_t ex_rs,
  input  reg_addr_t ex_rt,
  input  reg_addr_t mem_dst,
  input  reg_addr_t wb_dst,
  input  logic      mem_regwrite,
  input  logic      wb_regwrite,
  output fwd_sel_t  fwd_a,
  output fwd_sel_t  fwd_b
);

  function automatic fwd_sel_t pick_src(input reg_addr_t src,
                                        input reg_addr_t m_dst, input logic m_we,
                                        input reg_addr_t w_dst, input logic w_we);
    if (m_we && m_dst != '0 && m_dst == src)
      return fwd_mem;   // Newer result wins
    else if (w_we && w_dst != '0 && w_dst == src)
      return fwd_wb;
    else
      return fwd_none;
  endfunction

  assign fwd_a = pick_src(ex_rs, mem_dst, mem_regwrite, wb_dst, wb_regwrite);
  assign fwd_b = pick_src(ex_rt, mem_dst, mem_regwrite, wb_dst, wb_regwrite);

endmodule

// ==== fetch/instr_fetch.sv ====
`timescale 1ns/1ps

module instr_fetch
  import mips_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  en,
  input  logic  pcsrc,
  input  word_t pcbranch,
  output word_t pc,
  output word_t pcplus4
);

  word_t pc_next;

  assign pcplus4 = pc + word_bytes;
  assign pc_next = pcsrc ? pcbranch : pcplus4;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      pc <= reset_pc;
    else if (en || pcsrc)   // Taken branch overrides a stall
      pc <= pc_next;
  end

endmodule

// ==== decode/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
  import mips_pkg::*;
(
  input  logic      clk,
  input  logic      we,
  input  reg_addr_t ra1,
  input  reg_addr_t ra2,
  input  reg_addr_t wa,
  input  word_t     wd,
  output word_t     rd1,
  output word_t     rd2
);

  word_t regs [reg_count];

  always_ff @(posedge clk)
  begin
    if (we && wa != '0)
      regs[wa] <= wd;
  end

  // Same-cycle write shows up on the read ports
  assign rd1 = (ra1 == '0) ? '0 : (we && ra1 == wa) ? wd : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : (we && ra2 == wa) ? wd : regs[ra2];

endmodule

// ==== decode/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode
  import mips_pkg::*;
(
  input  logic      clk,
  input  word_t     instr,
  input  logic      wb_regwrite,
  input  reg_addr_t wb_dst,
  input  word_t     wb_writedata,
  output logic      regwrite,
  output logic      memtoreg,
  output logic      memwrite,
  output logic      branch,
  output logic      branch_ne,
  output logic      alusrc,
  output logic      regdst,
  output alu_op_t   alu_op,
  output reg_addr_t rs,
  output reg_addr_t rt,
  output reg_addr_t rd,
  output word_t     rd1,
  output word_t     rd2,
  output word_t     imm
);

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign imm    = {{16{instr[15]}}, instr[15:0]};

  always_comb
  begin
    regwrite  = 1'b0;   // Anything unknown stays a nop
    memtoreg  = 1'b0;
    memwrite  = 1'b0;
    branch    = 1'b0;
    branch_ne = 1'b0;
    alusrc    = 1'b0;
    regdst    = 1'b0;
    alu_op    = alu_and;
    case (opcode)
      op_rtype:
      begin
        regdst   = 1'b1;
        regwrite = 1'b1;
        case (funct)
          fn_add, fn_addu: alu_op = alu_add;
          fn_sub, fn_subu: alu_op = alu_sub;
          fn_and:          alu_op = alu_and;
          fn_or:           alu_op = alu_or;
          fn_slt:          alu_op = alu_slt;
          default:
          begin
            regdst   = 1'b0;   // Includes the all-zero nop
            regwrite = 1'b0;
          end
        endcase
      end
      op_lw:
      begin
        regwrite = 1'b1;
        memtoreg = 1'b1;
        alusrc   = 1'b1;
        alu_op   = alu_add;
      end
      op_sw:
      begin
        memwrite = 1'b1;
        alusrc   = 1'b1;
        alu_op   = alu_add;
      end
      op_beq, op_bne:
      begin
        branch    = 1'b1;
        branch_ne = (opcode == op_bne);
        alu_op    = alu_sub;   // Compare through the zero flag
      end
      op_addi, op_addiu:
      begin
        regwrite = 1'b1;
        alusrc   = 1'b1;
        alu_op   = alu_add;
      end
      default: ;
    endcase
  end

  reg_file u_reg_file (
    .clk (clk),
    .we  (wb_regwrite),
    .ra1 (rs),
    .ra2 (rt),
    .wa  (wb_dst),
    .wd  (wb_writedata),
    .rd1 (rd1),
    .rd2 (rd2)
  );

endmodule

// ==== execute/execute.sv ====
`timescale 1ns/1ps

module execute
  import mips_pkg::*;
(
  input  logic      alusrc,
  input  logic      regdst,
  input  logic      branch,
  input  logic      branch_ne,
  input  alu_op_t   alu_op,
  input  reg_addr_t rt,
  input  reg_addr_t rd,
  input  word_t     rd1,
  input  word_t     rd2,
  input  word_t     imm,
  input  word_t     pcplus4,
  input  word_t     mem_aluout,
  input  word_t     wb_writedata,
  input  fwd_sel_t  fwd_a,
  input  fwd_sel_t  fwd_b,
  output word_t     aluout,
  output word_t     storedata,
  output word_t     pcbranch,
  output reg_addr_t dst,
  output logic      pcsrc
);

  word_t src_a;
  word_t src_b;
  logic  zero;

  // --------------------
  // Operand forwarding
  always_comb
  begin
    case (fwd_a)
      fwd_mem: src_a = mem_aluout;
      fwd_wb:  src_a = wb_writedata;
      default: src_a = rd1;
    endcase
  end

  always_comb
  begin
    case (fwd_b)
      fwd_mem: storedata = mem_aluout;
      fwd_wb:  storedata = wb_writedata;
      default: storedata = rd2;
    endcase
  end

  assign src_b = alusrc ? imm : storedata;

  // --------------------
  // ALU
  always_comb
  begin
    case (alu_op)
      alu_and: aluout = src_a & src_b;
      alu_or:  aluout = src_a | src_b;
      alu_add: aluout = src_a + src_b;
      alu_sub: aluout = src_a - src_b;
      alu_slt: aluout = {31'b0, $signed(src_a) < $signed(src_b)};
      default: aluout = '0;
    endcase
  end

  assign zero = (aluout == '0);

  assign pcbranch = pcplus4 + {imm[29:0], 2'b00};
  assign pcsrc    = branch & (branch_ne ? ~zero : zero);
  assign dst      = regdst ? rd : rt;

endmodule

// ==== hdl/mips_pipe.sv ====
`timescale 1ns/1ps

module mips_pipe
  import mips_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  output word_t pc,
  input  word_t instr,
  output logic  memwrite,
  output word_t memaddr,
  output word_t memwritedata,
  input  word_t memreaddata
);

  logic      stall, flush;
  fwd_sel_t  fwd_a, fwd_b;
  word_t     if_pcplus4;

  word_t     id_instr, id_pcplus4, id_rd1, id_rd2, id_imm;
  logic      id_regwrite, id_memtoreg, id_memwrite, id_branch, id_branch_ne;
  logic      id_alusrc, id_regdst;
  alu_op_t   id_alu_op;
  reg_addr_t id_rs, id_rt, id_rd;

  logic      ex_regwrite, ex_memtoreg, ex_memwrite, ex_branch, ex_branch_ne;
  logic      ex_alusrc, ex_regdst, ex_pcsrc;
  alu_op_t   ex_alu_op;
  reg_addr_t ex_rs, ex_rt, ex_rd, ex_dst;
  word_t     ex_rd1, ex_rd2, ex_imm, ex_pcplus4;
  word_t     ex_aluout, ex_storedata, ex_pcbranch;

  logic      mem_regwrite, mem_memtoreg;
  reg_addr_t mem_dst;
  word_t     mem_aluout, mem_storedata;

  logic      wb_regwrite, wb_memtoreg;
  reg_addr_t wb_dst;
  word_t     wb_readdata, wb_aluout, wb_writedata;

  hazard_unit u_hazard_unit (
    .id_rs       (id_rs),
    .id_rt       (id_rt),
    .ex_rt       (ex_rt),
    .ex_memtoreg (ex_memtoreg),
    .ex_pcsrc    (ex_pcsrc),
    .stall       (stall),
    .flush       (flush)
  );

  forward_unit u_forward_unit (
    .ex_rs        (ex_rs),
    .ex_rt        (ex_rt),
    .mem_dst      (mem_dst),
    .wb_dst       (wb_dst),
    .mem_regwrite (mem_regwrite),
    .wb_regwrite  (wb_regwrite),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b)
  );

  instr_fetch u_instr_fetch (
    .clk      (clk),
    .rst_n    (rst_n),
    .en       (~stall),
    .pcsrc    (ex_pcsrc),
    .pcbranch (ex_pcbranch),
    .pc       (pc),
    .pcplus4  (if_pcplus4)
  );

  // --------------------
  // IF/ID
  always_ff @(posedge clk)
  begin
    if (!rst_n || flush)
      id_instr <= '0;            // All-zero word is a nop
    else if (!stall)
      id_instr <= instr;
  end

  always_ff @(posedge clk)
  begin
    if (!stall)
      id_pcplus4 <= if_pcplus4;
  end

  instr_decode u_instr_decode (
    .clk          (clk),
    .instr        (id_instr),
    .wb_regwrite  (wb_regwrite),
    .wb_dst       (wb_dst),
    .wb_writedata (wb_writedata),
    .regwrite     (id_regwrite),
    .memtoreg     (id_memtoreg),
    .memwrite     (id_memwrite),
    .branch       (id_branch),
    .branch_ne    (id_branch_ne),
    .alusrc       (id_alusrc),
    .regdst       (id_regdst),
    .alu_op       (id_alu_op),
    .rs           (id_rs),
    .rt           (id_rt),
    .rd           (id_rd),
    .rd1          (id_rd1),
    .rd2          (id_rd2),
    .imm          (id_imm)
  );

  // --------------------
  // ID/EX
  always_ff @(posedge clk)
  begin
    if (!rst_n || flush || stall)
    begin
      ex_regwrite  <= 1'b0;      // Bubble
      ex_memtoreg  <= 1'b0;
      ex_memwrite  <= 1'b0;
      ex_branch    <= 1'b0;
      ex_branch_ne <= 1'b0;
    end
    else
    begin
      ex_regwrite  <= id_regwrite;
      ex_memtoreg  <= id_memtoreg;
      ex_memwrite  <= id_memwrite;
      ex_branch    <= id_branch;
      ex_branch_ne <= id_branch_ne;
    end
  end

  always_ff @(posedge clk)
  begin
    ex_alusrc  <= id_alusrc;
    ex_regdst  <= id_regdst;
    ex_alu_op  <= id_alu_op;
    ex_rs      <= id_rs;
    ex_rt      <= id_rt;
    ex_rd      <= id_rd;
    ex_rd1     <= id_rd1;
    ex_rd2     <= id_rd2;
    ex_imm     <= id_imm;
    ex_pcplus4 <= id_pcplus4;
  end

  execute u_execute (
    .alusrc       (ex_alusrc),
    .regdst       (ex_regdst),
    .branch       (ex_branch),
    .branch_ne    (ex_branch_ne),
    .alu_op       (ex_alu_op),
    .rt           (ex_rt),
    .rd           (ex_rd),
    .rd1          (ex_rd1),
    .rd2          (ex_rd2),
    .imm          (ex_imm),
    .pcplus4      (ex_pcplus4),
    .mem_aluout   (mem_aluout),
    .wb_writedata (wb_writedata),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b),
    .aluout       (ex_aluout),
    .storedata    (ex_storedata),
    .pcbranch     (ex_pcbranch),
    .dst          (ex_dst),
    .pcsrc        (ex_pcsrc)
  );

  // --------------------
  // EX/MEM
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      mem_regwrite <= 1'b0;
      mem_memtoreg <= 1'b0;
      memwrite     <= 1'b0;
    end
    else
    begin
      mem_regwrite <= ex_regwrite;
      mem_memtoreg <= ex_memtoreg;
      memwrite     <= ex_memwrite;
    end
  end

  always_ff @(posedge clk)
  begin
    mem_aluout    <= ex_aluout;
    mem_storedata <= ex_storedata;
    mem_dst       <= ex_dst;
  end

  assign memaddr      = mem_aluout;
  assign memwritedata = mem_storedata;

  // --------------------
  // MEM/WB
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wb_regwrite <= 1'b0;
      wb_memtoreg <= 1'b0;
    end
    else
    begin
      wb_regwrite <= mem_regwrite;
      wb_memtoreg <= mem_memtoreg;
    end
  end

  always_ff @(posedge clk)
  begin
    wb_readdata <= memreaddata;
    wb_aluout   <= mem_aluout;
    wb_dst      <= mem_dst;
  end

  assign wb_writedata = wb_memtoreg ? wb_readdata : wb_aluout;

endmodule

// ==== tb/mips_pipe_tb.sv ====
`timescale 1ns/1ps

module mips_pipe_tb
  import mips_pkg::*;
();

  localparam int mem_words       = 256;
  localparam int reset_cycles    = 10;
  localparam int test_count      = 6;
  localparam int cycles_per_test = 60;
  localparam int timeout_cycles  = test_count * (cycles_per_test + reset_cycles);
  localparam int drain_cycles    = 5;   // Last fetch through writeback

  logic  clk;
  logic  rst_n;
  logic  memwrite;
  word_t pc, instr, memaddr, memwritedata, memreaddata;

  word_t imem [mem_words];
  word_t dmem [mem_words];
  int    fill_ptr;
  int    cycle_count;
  word_t rng_state;

  word_t st_addr  [$];
  word_t st_data  [$];
  word_t exp_addr [$];
  word_t exp_data [$];
  word_t pc_trace [$];
  word_t exp_pc   [$];

  mips_pipe u_mips_pipe (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc           (pc),
    .instr        (instr),
    .memwrite     (memwrite),
    .memaddr      (memaddr),
    .memwritedata (memwritedata),
    .memreaddata  (memreaddata)
  );

  always #5 clk = ~clk;

  // Both memories answer in the same cycle
  assign instr       = imem[pc[9:2]];
  assign memreaddata = dmem[memaddr[9:2]];

  always @(posedge clk)
  begin
    if (memwrite === 1'b1)
    begin
      dmem[memaddr[9:2]] <= memwritedata;
      st_addr.push_back(memaddr);
      st_data.push_back(memwritedata);
    end
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles)
      report_failure("timeout: the tests did not finish within the cycle limit");
  end

  // --------------------
  // Helpers
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected)
      report_failure($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
  endtask

  task automatic check_pc(input string name, input word_t expected, input word_t actual);
    if (actual !== expected)
      report_failure($sformatf("mismatch %s: expected pc %h, actual pc %h", name, expected,
                               actual));
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      report_failure($sformatf("mismatch %s: expected %b, actual %b", name, expected, actual));
  endtask

  function automatic word_t next_random();
    word_t x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic word_t r_type(input logic [5:0] fn, input reg_addr_t rs,
                                   input reg_addr_t rt, input reg_addr_t rd);
    return {op_rtype, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t i_type(input logic [5:0] op, input reg_addr_t rs,
                                   input reg_addr_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t sext(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic word_t less_signed(input word_t a, input word_t b);
    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
  endfunction

  task automatic emit(input word_t w);
    imem[fill_ptr] = w;
    fill_ptr++;
  endtask

  task automatic expect_store(input word_t addr, input word_t data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic start_test();
    int i;
    rst_n = 1'b0;
    for (i = 0; i < mem_words; i++)
    begin
      imem[i] = '0;   // nop
      dmem[i] = '0;
    end
    fill_ptr = 0;
    exp_addr.delete();
    exp_data.delete();
    exp_pc.delete();
    pc_trace.delete();
  endtask

  // Release reset, follow pc to the end of the program, then drain
  task automatic run_program();
    word_t end_pc;
    end_pc = word_t'(fill_ptr) * word_bytes;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    st_addr.delete();
    st_data.delete();
    pc_trace.push_back(pc);
    while (pc !== end_pc)
    begin
      @(posedge clk);
      #1;
      pc_trace.push_back(pc);
    end
    repeat (drain_cycles) @(posedge clk);
    #1;
  endtask

  task automatic verify_stores(input string name);
    int i;
    check_word({name, " store count"}, word_t'(exp_addr.size()), word_t'(st_addr.size()));
    for (i = 0; i < exp_addr.size(); i++)
    begin
      check_word($sformatf("%s store %0d address", name, i), exp_addr[i], st_addr[i]);
      check_word($sformatf("%s store %0d data", name, i), exp_data[i], st_data[i]);
    end
  endtask

  task automatic verify_trace(input string name);
    int i;
    check_word({name, " pc count"}, word_t'(exp_pc.size()), word_t'(pc_trace.size()));
    for (i = 0; i < exp_pc.size(); i++)
      check_pc($sformatf("%s pc %0d", name, i), exp_pc[i], pc_trace[i]);
  endtask

  // --------------------
  // Tests
  task automatic test_reset();
    int k;
    start_test();
    for (k = 0; k < reset_cycles; k++)
    begin
      @(posedge clk);
      #1;
      check_flag("reset memwrite", 1'b0, memwrite);
      check_pc("reset pc", reset_pc, pc);
    end
    rst_n = 1'b1;
    check_pc("pc after reset", reset_pc, pc);
    for (k = 1; k <= 8; k++)
    begin
      @(posedge clk);
      #1;
      check_pc("pc step", reset_pc + word_bytes * word_t'(k), pc);
      check_flag("idle memwrite", 1'b0, memwrite);
    end
  endtask

  task automatic test_alu();
    word_t       a, b, r3, r4, r5, r6, r7;
    logic [15:0] k;
    a = next_random();
    b = next_random();
    k = 16'(next_random());
    start_test();
    dmem[0] = a;
    dmem[1] = b;
    emit(i_type(op_lw, 5'd0, 5'd1, 16'd0));
    emit(i_type(op_lw, 5'd0, 5'd2, 16'd4));
    emit(r_type(fn_add, 5'd1, 5'd2, 5'd3));
    emit(i_type(op_sw, 5'd0, 5'd3, 16'd64));
    emit(r_type(fn_sub, 5'd1, 5'd3, 5'd4));
    emit(i_type(op_sw, 5'd0, 5'd4, 16'd68));
    emit(r_type(fn_and, 5'd4, 5'd1, 5'd5));
    emit(i_type(op_sw, 5'd0, 5'd5, 16'd72));
    emit(r_type(fn_or, 5'd5, 5'd2, 5'd6));
    emit(i_type(op_sw, 5'd0, 5'd6, 16'd76));
    emit(r_type(fn_slt, 5'd6, 5'd4, 5'd7));
    emit(i_type(op_sw, 5'd0, 5'd7, 16'd80));
    emit(i_type(op_addi, 5'd7, 5'd8, k));
    emit(i_type(op_sw, 5'd0, 5'd8, 16'd84));
    emit(r_type(fn_slt, 5'd2, 5'd1, 5'd9));
    emit(i_type(op_sw, 5'd0, 5'd9, 16'd88));
    r3 = a + b;
    r4 = a - r3;
    r5 = r4 & a;
    r6 = r5 | b;
    r7 = less_signed(r6, r4);
    expect_store(32'd64, r3);
    expect_store(32'd68, r4);
    expect_store(32'd72, r5);
    expect_store(32'd76, r6);
    expect_store(32'd80, r7);
    expect_store(32'd84, r7 + sext(k));
    expect_store(32'd88, less_signed(b, a));
    run_program();
    verify_stores("alu");
  endtask

  task automatic test_load_use();
    word_t       c, d;
    logic [15:0] k;
    c = next_random();
    d = next_random();
    k = 16'(next_random());
    start_test();
    dmem[2] = c;
    dmem[3] = d;
    emit(i_type(op_addiu, 5'd0, 5'd3, k));
    emit(i_type(op_lw, 5'd0, 5'd1, 16'd8));
    emit(r_type(fn_add, 5'd1, 5'd3, 5'd2));   // Needs the load result
    emit(i_type(op_sw, 5'd0, 5'd2, 16'd96));
    emit(i_type(op_lw, 5'd0, 5'd4, 16'd12));
    emit(i_type(op_sw, 5'd0, 5'd4, 16'd100));
    expect_store(32'd96, c + sext(k));
    expect_store(32'd100, d);
    run_program();
    verify_stores("load_use");
  endtask

  task automatic test_branch_taken();
    logic [15:0] k;
    int          i;
    word_t       pcs [12] = '{0, 4, 8, 12, 16, 24, 28, 32, 36, 40, 48, 52};
    k = 16'(next_random());
    start_test();
    emit(i_type(op_addi, 5'd0, 5'd1, k));
    emit(i_type(op_addi, 5'd0, 5'd2, k));
    emit(i_type(op_beq, 5'd1, 5'd2, 16'd3));   // To 24
    emit(i_type(op_sw, 5'd0, 5'd1, 16'd160));
    emit(i_type(op_sw, 5'd0, 5'd1, 16'd164));
    emit(i_type(op_sw, 5'd0, 5'd1, 16'd168));
    emit(i_type(op_sw, 5'd0, 5'd1, 16'd172));
    emit(i_type(op_addi, 5'd1, 5'd3, 16'd1));
    emit(i_type(op_bne, 5'd1, 5'd3, 16'd3));   // To 48
    emit(i_type(op_sw, 5'd0, 5'd3, 16'd176));
    emit(i_type(op_sw, 5'd0, 5'd3, 16'd180));
    emit(i_type(op_sw, 5'd0, 5'd3, 16'd184));
    emit(i_type(op_sw, 5'd0, 5'd3, 16'd188));
    expect_store(32'd172, sext(k));
    expect_store(32'd188, sext(k) + 32'd1);
    for (i = 0; i < 12; i++)
      exp_pc.push_back(pcs[i]);
    run_program();
    verify_stores("branch_taken");
    verify_trace("branch_taken");
  endtask

  task automatic test_branch_not_taken();
    logic [15:0] k;
    int          i;
    k = 16'(next_random());
    start_test();
    emit(i_type(op_addi, 5'd0, 5'd1, k));
    emit(i_type(op_addi, 5'd1, 5'd2, 16'd1));
    emit(i_type(op_beq, 5'd1, 5'd2, 16'd3));
    emit(i_type(op_sw, 5'd0, 5'd1, 16'd192));
    emit(i_type(op_addi, 5'd1, 5'd3, 16'd0));
    emit(i_type(op_bne, 5'd1, 5'd3, 16'd3));
    emit(i_type(op_sw, 5'd0, 5'd2, 16'd196));
    emit(i_type(op_sw, 5'd0, 5'd3, 16'd200));
    expect_store(32'd192, sext(k));
    expect_store(32'd196, sext(k) + 32'd1);
    expect_store(32'd200, sext(k));
    for (i = 0; i <= 8; i++)
      exp_pc.push_back(word_bytes * word_t'(i));
    run_program();
    verify_stores("branch_not_taken");
    verify_trace("branch_not_taken");
  endtask

  task automatic test_reg_zero();
    logic [15:0] k;
    k = 16'(next_random()) | 16'd1;   // Never zero
    start_test();
    emit(i_type(op_addi, 5'd0, 5'd0, k));
    emit(i_type(op_sw, 5'd0, 5'd0, 16'd204));
    emit(r_type(fn_add, 5'd0, 5'd0, 5'd1));
    emit(i_type(op_sw, 5'd0, 5'd1, 16'd208));
    expect_store(32'd204, 32'd0);
    expect_store(32'd208, 32'd0);
    run_program();
    verify_stores("reg_zero");
  endtask

  // --------------------
  initial
  begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    cycle_count = 0;
    fill_ptr    = 0;
    rng_state   = 32'h08a2_d50c;
    test_reset();
    test_alu();
    test_load_use();
    test_branch_taken();
    test_branch_not_taken();
    test_reg_zero();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== mips_pipe.f ====
common/mips_pkg.sv
hdl/hazard_unit.sv
hdl/forward_unit.sv
fetch/instr_fetch.sv
decode/reg_file.sv
decode/instr_decode.sv
execute/execute.sv
hdl/mips_pipe.sv
tb/mips_pipe_tb.sv
